// ==== src/arcade_config.svh ====
/*
 * arcade io wrapper configuration
 * rom store geometry, store latency and keyboard scancodes
 */
`ifndef ARCADE_CONFIG_SVH
`define ARCADE_CONFIG_SVH

// ==========================================================================
// rom store geometry
// ==========================================================================
`define ROM_WORDS       24576   // 48 KiB of rom as 16-bit words
`define ROM_WORD_ABITS  15
`define SND_WORD_BASE   16384   // sound board rom starts here
`define CPU_BYTE_ABITS  15
`define SND_BYTE_ABITS  14

// cycles from a req seen by the store to its ack
`define STORE_WAIT      2

// ==========================================================================
// ps/2 set 2 scancodes
// ==========================================================================
`define KEY_UP      8'h75   // cursor up
`define KEY_DOWN    8'h72   // cursor down
`define KEY_FIRE    8'h29   // space
`define KEY_BOMB    8'h11   // alt
`define KEY_COIN    8'h76   // esc
`define KEY_START1  8'h05   // f1
`define KEY_START2  8'h06   // f2

`endif

// ==== src/arcade_pkg.sv ====
/*
 * arcade io shared types
 * rom word views, memory request command and player control word
 */
`default_nettype none

`include "arcade_config.svh"

package arcade_pkg;

	// two byte lanes of one rom word, hi is lane 1
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} rom_bytes_t;

	// one rom word, seen whole or as two lanes
	typedef union packed {
		logic [15:0] word;      // for moving data around
		rom_bytes_t  bytes;     // for lane writes and byte selection
	} rom_word_u;

	// one request on a four-phase req/ack link
	typedef struct packed {
		logic                       we;     // 1 = write
		logic [1:0]                 be;     // byte enables, bit 1 = hi lane
		logic [`ROM_WORD_ABITS-1:0] addr;   // word address
		rom_word_u                  wdata;
	} mem_req_t;

	// control word handed to the core
	typedef struct packed {
		logic up;
		logic down;
		logic fire;
		logic bomb;
		logic coin;
		logic start1;
		logic start2;
	} player_ctrl_t;

endpackage

`default_nettype wire

// ==== src/rom_loader.sv ====
/*
 * rom loader
 * turns the download byte stream into byte-lane store writes,
 * tracks rom_loaded and holds the core in reset until then
 */
`timescale 1ns/10ps
`default_nettype none

`include "arcade_config.svh"

module rom_loader (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        ioctl_download,
	input  wire                        ioctl_wr,
	input  wire [`ROM_WORD_ABITS:0]    ioctl_addr,     // byte address
	input  wire [7:0]                  ioctl_dout,
	input  wire                        reset_req,
	input  wire                        mem_ack,
	output logic                       ioctl_ready,
	output logic                       mem_req,
	output arcade_pkg::mem_req_t       mem_cmd,
	output logic                       core_reset
);

	logic download_q;   // previous ioctl_download
	logic rom_loaded;
	logic wr_accept;

	// a byte only counts while a download runs and no write is pending
	assign wr_accept = ioctl_download & ioctl_wr & ioctl_ready;

	// ======================================================================
	// handshake and load status
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_ready <= 1'b1;
			mem_req     <= 1'b0;
			download_q  <= 1'b0;
			rom_loaded  <= 1'b0;
			core_reset  <= 1'b1;
		end else begin
			download_q <= ioctl_download;

			// a new download invalidates the image until it ends
			if (ioctl_download)
				rom_loaded <= 1'b0;
			else if (download_q)
				rom_loaded <= 1'b1;   // falling edge of download

			core_reset <= ~rom_loaded | reset_req;

			if (ioctl_ready) begin
				if (wr_accept) begin
					ioctl_ready <= 1'b0;
					mem_req     <= 1'b1;
				end
			end else if (mem_req) begin
				if (mem_ack)
					mem_req <= 1'b0;
			end else if (!mem_ack) begin
				ioctl_ready <= 1'b1;  // four phases done
			end
		end
	end

	// write command, byte copied to both lanes
	always_ff @(posedge clk_sys) begin
		if (wr_accept) begin
			mem_cmd.we         <= 1'b1;
			mem_cmd.be         <= ioctl_addr[0] ? 2'b10 : 2'b01;
			mem_cmd.addr       <= ioctl_addr[`ROM_WORD_ABITS:1];
			mem_cmd.wdata.word <= {ioctl_dout, ioctl_dout};
		end
	end

endmodule

`default_nettype wire

// ==== src/rom_fetch.sv ====
/*
 * rom fetch port
 * serves byte reads from one core board out of a last-word cache,
 * fetching a new word from the store on a miss
 */
`timescale 1ns/10ps
`default_nettype none

`include "arcade_config.svh"

module rom_fetch #(
	parameter int BYTE_ABITS = 15,
	parameter int BASE_WORD  = 0
) (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        flush,
	input  wire                        rd,
	input  wire [BYTE_ABITS-1:0]       addr,
	input  wire                        mem_ack,
	input  arcade_pkg::rom_word_u      mem_rdata,
	output logic [7:0]                 data,
	output logic                       valid,
	output logic                       mem_req,
	output arcade_pkg::mem_req_t       mem_cmd
);

	localparam int WABITS = BYTE_ABITS - 1;

	logic [WABITS-1:0]     word_addr;
	logic [WABITS-1:0]     cache_addr;
	arcade_pkg::rom_word_u cache_word;
	logic                  sel_hi;         // byte lane of the last read
	logic                  busy;
	logic                  hit;
	logic                  miss;
	logic                  capture;

	assign word_addr = addr[BYTE_ABITS-1:1];
	assign busy      = mem_req | mem_ack;  // until ack has fallen
	assign hit       = valid && (word_addr == cache_addr);
	assign miss      = rd && !busy && !hit && !flush;
	assign capture   = mem_req & mem_ack;

	// ======================================================================
	// cache state and request
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			valid   <= 1'b0;
			mem_req <= 1'b0;
		end else begin
			if (capture)
				mem_req <= 1'b0;
			else if (miss)
				mem_req <= 1'b1;

			// other word asked for, even while the link is still busy
			if (flush || (rd && valid && !hit))
				valid <= 1'b0;    // drop the cached word
			else if (capture)
				valid <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rd && (hit || miss))
			sel_hi <= addr[0];
		if (miss) begin
			cache_addr         <= word_addr;
			mem_cmd.we         <= 1'b0;
			mem_cmd.be         <= 2'b11;
			mem_cmd.addr       <= `ROM_WORD_ABITS'(BASE_WORD) + `ROM_WORD_ABITS'(word_addr);
			mem_cmd.wdata.word <= '0;
		end
		if (capture)
			cache_word <= mem_rdata;
	end

	// odd byte address takes the high lane
	assign data = sel_hi ? cache_word.bytes.hi : cache_word.bytes.lo;

endmodule

`default_nettype wire

// ==== src/rom_port_arbiter.sv ====
/*
 * rom port arbiter
 * shares the store between the loader and two fetch ports,
 * fixed priority loader > cpu > sound, one grant per four phases
 */
`timescale 1ns/10ps
`default_nettype none

module rom_port_arbiter (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        ld_req,
	input  arcade_pkg::mem_req_t       ld_cmd,
	input  wire                        cpu_req,
	input  arcade_pkg::mem_req_t       cpu_cmd,
	input  wire                        snd_req,
	input  arcade_pkg::mem_req_t       snd_cmd,
	input  wire                        st_ack,
	input  arcade_pkg::rom_word_u      st_rdata,
	output logic                       ld_ack,
	output logic                       cpu_ack,
	output arcade_pkg::rom_word_u      cpu_rdata,
	output logic                       snd_ack,
	output arcade_pkg::rom_word_u      snd_rdata,
	output logic                       st_req,
	output arcade_pkg::mem_req_t       st_cmd
);

	localparam logic [1:0] G_LD  = 2'd0;
	localparam logic [1:0] G_CPU = 2'd1;
	localparam logic [1:0] G_SND = 2'd2;

	logic       busy;       // a grant is in progress
	logic [1:0] gnt;
	logic       win_req;
	logic       win_ack;

	// winner's side of its link
	always_comb begin
		case (gnt)
			G_LD: begin
				win_req = ld_req;
				win_ack = ld_ack;
			end
			G_CPU: begin
				win_req = cpu_req;
				win_ack = cpu_ack;
			end
			default: begin
				win_req = snd_req;
				win_ack = snd_ack;
			end
		endcase
	end

	// ======================================================================
	// grant and handshake relay
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			gnt     <= G_LD;
			st_req  <= 1'b0;
			ld_ack  <= 1'b0;
			cpu_ack <= 1'b0;
			snd_ack <= 1'b0;
		end else begin
			if (!busy) begin
				if (ld_req || cpu_req || snd_req) begin
					busy   <= 1'b1;
					st_req <= 1'b1;
					if (ld_req)
						gnt <= G_LD;
					else if (cpu_req)
						gnt <= G_CPU;
					else
						gnt <= G_SND;
				end
			end else begin
				st_req <= win_req;            // follows the winner's req
				if (win_ack && !st_ack)
					busy <= 1'b0;             // winner's ack drops now
			end

			ld_ack  <= busy && (gnt == G_LD)  && st_ack;
			cpu_ack <= busy && (gnt == G_CPU) && st_ack;
			snd_ack <= busy && (gnt == G_SND) && st_ack;
		end
	end

	// command and read data, no reset
	always_ff @(posedge clk_sys) begin
		if (!busy) begin
			if (ld_req)
				st_cmd <= ld_cmd;
			else if (cpu_req)
				st_cmd <= cpu_cmd;
			else
				st_cmd <= snd_cmd;
		end
		if (busy && st_ack && !win_ack) begin
			if (gnt == G_CPU)
				cpu_rdata <= st_rdata;
			if (gnt == G_SND)
				snd_rdata <= st_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== src/rom_store.sv ====
/*
 * rom store
 * word memory with byte-lane writes behind a req/ack port,
 * ack follows req by a fixed wait
 */
`timescale 1ns/10ps
`default_nettype none

`include "arcade_config.svh"

module rom_store (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        req,
	input  arcade_pkg::mem_req_t       cmd,
	output logic                       ack,
	output arcade_pkg::rom_word_u      rdata
);

	localparam int CNT_W = $clog2(`STORE_WAIT + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`STORE_WAIT - 1);

	arcade_pkg::rom_word_u mem [`ROM_WORDS];

	logic [CNT_W-1:0] wait_cnt;
	logic             fire;       // access happens with ack rising

	assign fire = req && !ack && (wait_cnt == CNT_LAST);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ack      <= 1'b0;
			wait_cnt <= '0;
		end else if (req && !ack) begin
			if (wait_cnt == CNT_LAST) begin
				ack      <= 1'b1;
				wait_cnt <= '0;
			end else begin
				wait_cnt <= wait_cnt + 1'b1;
			end
		end else if (!req) begin
			ack <= 1'b0;          // one cycle after req falls
		end
	end

	// memory array, only enabled lanes written
	always_ff @(posedge clk_sys) begin
		if (fire) begin
			if (cmd.we) begin
				if (cmd.be[1])
					mem[cmd.addr].bytes.hi <= cmd.wdata.bytes.hi;
				if (cmd.be[0])
					mem[cmd.addr].bytes.lo <= cmd.wdata.bytes.lo;
			end else begin
				rdata <= mem[cmd.addr];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/control_mapper.sv ====
/*
 * control mapper
 * latches keyboard make/break codes and merges them with both
 * joysticks into one registered player control word
 */
`timescale 1ns/10ps
`default_nettype none

`include "arcade_config.svh"

module control_mapper (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        key_strobe,
	input  wire                        key_pressed,
	input  wire [7:0]                  key_code,
	input  wire [7:0]                  joystick_0,
	input  wire [7:0]                  joystick_1,
	output arcade_pkg::player_ctrl_t   ctrl
);

	arcade_pkg::player_ctrl_t keys;       // key latches
	arcade_pkg::player_ctrl_t keys_nxt;
	arcade_pkg::player_ctrl_t joy;

	// key latch update, unknown codes leave everything alone
	always_comb begin
		keys_nxt = keys;
		if (key_strobe) begin
			case (key_code)
				`KEY_UP:     keys_nxt.up     = key_pressed;
				`KEY_DOWN:   keys_nxt.down   = key_pressed;
				`KEY_FIRE:   keys_nxt.fire   = key_pressed;
				`KEY_BOMB:   keys_nxt.bomb   = key_pressed;
				`KEY_COIN:   keys_nxt.coin   = key_pressed;
				`KEY_START1: keys_nxt.start1 = key_pressed;
				`KEY_START2: keys_nxt.start2 = key_pressed;
				default: ;
			endcase
		end
	end

	// either stick drives the same player
	always_comb begin
		joy      = '0;
		joy.up   = joystick_0[3] | joystick_1[3];
		joy.down = joystick_0[2] | joystick_1[2];
		joy.fire = joystick_0[4] | joystick_1[4];
		joy.bomb = joystick_0[5] | joystick_1[5];
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			keys <= '0;
			ctrl <= '0;
		end else begin
			keys <= keys_nxt;
			ctrl <= keys_nxt | joy;   // one cycle from strobe or stick
		end
	end

endmodule

`default_nettype wire

// ==== src/arcade_io_top.sv ====
/*
 * arcade io top
 * loader and two fetch ports share the rom store through the arbiter,
 * control mapper builds the player word
 */
`timescale 1ns/10ps
`default_nettype none

`include "arcade_config.svh"

module arcade_io_top (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        ioctl_download,
	input  wire                        ioctl_wr,
	input  wire [`ROM_WORD_ABITS:0]    ioctl_addr,
	input  wire [7:0]                  ioctl_dout,
	input  wire                        reset_req,
	input  wire                        cpu_rom_rd,
	input  wire [`CPU_BYTE_ABITS-1:0]  cpu_rom_addr,
	input  wire                        snd_rom_rd,
	input  wire [`SND_BYTE_ABITS-1:0]  snd_rom_addr,
	input  wire                        key_strobe,
	input  wire                        key_pressed,
	input  wire [7:0]                  key_code,
	input  wire [7:0]                  joystick_0,
	input  wire [7:0]                  joystick_1,
	output logic                       ioctl_ready,
	output logic                       core_reset,
	output logic [7:0]                 cpu_rom_data,
	output logic                       cpu_rom_valid,
	output logic [7:0]                 snd_rom_data,
	output logic                       snd_rom_valid,
	output arcade_pkg::player_ctrl_t   ctrl
);

	// ======================================================================
	// request links
	// ======================================================================
	logic                  ld_req, ld_ack;
	arcade_pkg::mem_req_t  ld_cmd;
	logic                  cpu_req, cpu_ack;
	arcade_pkg::mem_req_t  cpu_cmd;
	arcade_pkg::rom_word_u cpu_rdata;
	logic                  snd_req, snd_ack;
	arcade_pkg::mem_req_t  snd_cmd;
	arcade_pkg::rom_word_u snd_rdata;
	logic                  st_req, st_ack;
	arcade_pkg::mem_req_t  st_cmd;
	arcade_pkg::rom_word_u st_rdata;

	rom_loader rom_loader_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.reset_req      (reset_req),
		.mem_ack        (ld_ack),
		.ioctl_ready    (ioctl_ready),
		.mem_req        (ld_req),
		.mem_cmd        (ld_cmd),
		.core_reset     (core_reset)
	);

	rom_fetch #(.BYTE_ABITS(`CPU_BYTE_ABITS), .BASE_WORD(0)) cpu_fetch (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.flush     (core_reset),
		.rd        (cpu_rom_rd),
		.addr      (cpu_rom_addr),
		.mem_ack   (cpu_ack),
		.mem_rdata (cpu_rdata),
		.data      (cpu_rom_data),
		.valid     (cpu_rom_valid),
		.mem_req   (cpu_req),
		.mem_cmd   (cpu_cmd)
	);

	rom_fetch #(.BYTE_ABITS(`SND_BYTE_ABITS), .BASE_WORD(`SND_WORD_BASE)) snd_fetch (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.flush     (core_reset),
		.rd        (snd_rom_rd),
		.addr      (snd_rom_addr),
		.mem_ack   (snd_ack),
		.mem_rdata (snd_rdata),
		.data      (snd_rom_data),
		.valid     (snd_rom_valid),
		.mem_req   (snd_req),
		.mem_cmd   (snd_cmd)
	);

	rom_port_arbiter rom_port_arbiter_i (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ld_req    (ld_req),
		.ld_cmd    (ld_cmd),
		.cpu_req   (cpu_req),
		.cpu_cmd   (cpu_cmd),
		.snd_req   (snd_req),
		.snd_cmd   (snd_cmd),
		.st_ack    (st_ack),
		.st_rdata  (st_rdata),
		.ld_ack    (ld_ack),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.snd_ack   (snd_ack),
		.snd_rdata (snd_rdata),
		.st_req    (st_req),
		.st_cmd    (st_cmd)
	);

	rom_store rom_store_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.req     (st_req),
		.cmd     (st_cmd),
		.ack     (st_ack),
		.rdata   (st_rdata)
	);

	control_mapper control_mapper_i (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.ctrl        (ctrl)
	);

endmodule

`default_nettype wire

// ==== bench/arcade_io_chk.sv ====
/*
 * handshake checker
 * four-phase req/ack rules for a group of links,
 * bound into the port arbiter and the rom store
 */
`timescale 1ns/10ps
`default_nettype none

module arcade_io_chk #(
	parameter int N = 1
) (
	input wire                                        clk_sys,
	input wire                                        rst_n,
	input wire [N-1:0]                                req,
	input wire [N-1:0]                                ack,
	input wire [N*$bits(arcade_pkg::mem_req_t)-1:0]   cmd
);

	localparam int CW = $bits(arcade_pkg::mem_req_t);

	// one winner at a time
	if (N > 1) begin : g_onehot
		ack_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n) $onehot0(ack))
			else $error("more than one ack high in the same cycle");
	end

	for (genvar i = 0; i < N; i++) begin : g_link
		req_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
			req[i] && !ack[i] |=> req[i])
			else $error("link %0d: req dropped before ack", i);

		ack_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
			$rose(ack[i]) |-> req[i])
			else $error("link %0d: ack rose without req", i);

		cmd_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
			req[i] && $past(req[i]) |-> cmd[i*CW +: CW] == $past(cmd[i*CW +: CW]))
			else $error("link %0d: command changed while req high", i);
	end

endmodule

// ==========================================================================
// attach to the arbiter's requester links and to the store port
// ==========================================================================
bind rom_port_arbiter arcade_io_chk #(.N(3)) arbiter_chk (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.req     ({snd_req, cpu_req, ld_req}),
	.ack     ({snd_ack, cpu_ack, ld_ack}),
	.cmd     ({snd_cmd, cpu_cmd, ld_cmd})
);

bind rom_store arcade_io_chk #(.N(1)) store_chk (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.req     (req),
	.ack     (ack),
	.cmd     (cmd)
);

`default_nettype wire

// ==== bench/arcade_io_tb.sv ====
/*
 * arcade io testbench
 * downloads a random rom image, reads it back through both fetch
 * ports, checks reset and flush, and drives the control mapper
 */
`timescale 1ns/10ps
`default_nettype none

`include "arcade_config.svh"

module arcade_io_tb;

	localparam int IMG_AW     = `ROM_WORD_ABITS + 1;   // byte address width
	localparam int CPU_AW     = `CPU_BYTE_ABITS;
	localparam int SND_AW     = `SND_BYTE_ABITS;
	localparam int CPU_BYTES  = 4096;
	localparam int SND_BYTES  = 2048;
	localparam int SND_BYTE0  = 2 * `SND_WORD_BASE;
	localparam int RELOAD     = 64;      // bytes rewritten per region
	localparam int N_READS    = 300;
	localparam int N_PAIRS    = 20;
	localparam int N_KEYS     = 200;
	localparam int WAIT_LIMIT = 200;     // any single wait, in cycles

	// run limit from the test lengths
	localparam int DL_BYTES   = CPU_BYTES + SND_BYTES + 2 * RELOAD;
	localparam int CYC_BYTE   = 16;
	localparam int N_FETCH    = 2 * N_READS + 6 * N_PAIRS + 8;
	localparam int CYC_FETCH  = 40;
	localparam int MAX_CYCLES = DL_BYTES * CYC_BYTE + N_FETCH * CYC_FETCH + N_KEYS * 3 + 5000;

	localparam int SIG_READY      = 0;
	localparam int SIG_CORE_RESET = 1;
	localparam int SIG_CPU_VALID  = 2;
	localparam int SIG_SND_VALID  = 3;

	logic                       clk_sys;
	logic                       rst_n;
	logic                       ioctl_download;
	logic                       ioctl_wr;
	logic [IMG_AW-1:0]          ioctl_addr;
	logic [7:0]                 ioctl_dout;
	logic                       reset_req;
	logic                       cpu_rom_rd;
	logic [CPU_AW-1:0]          cpu_rom_addr;
	logic                       snd_rom_rd;
	logic [SND_AW-1:0]          snd_rom_addr;
	logic                       key_strobe;
	logic                       key_pressed;
	logic [7:0]                 key_code;
	logic [7:0]                 joystick_0;
	logic [7:0]                 joystick_1;
	logic                       ioctl_ready;
	logic                       core_reset;
	logic [7:0]                 cpu_rom_data;
	logic                       cpu_rom_valid;
	logic [7:0]                 snd_rom_data;
	logic                       snd_rom_valid;
	arcade_pkg::player_ctrl_t   ctrl;

	logic [7:0]               image [0:2**IMG_AW-1];   // byte image as downloaded
	arcade_pkg::player_ctrl_t key_state;              // shadow of the key latches
	int   n_checks = 0;
	int   n_errors = 0;
	int   cycles = 0;
	int   cpu_req_cnt = 0;
	int   snd_req_cnt = 0;
	int   cpu_last = 0;
	int   snd_last = 0;
	logic cpu_valid_q;
	logic snd_valid_q;
	logic cpu_req_q;
	logic snd_req_q;

	arcade_io_top arcade_io_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ======================================================================
	// reference model
	// ======================================================================
	function automatic logic [7:0] exp_rom_byte(input logic snd, input int addr);
		int byte_addr;
		byte_addr = snd ? SND_BYTE0 + addr : addr;   // sound board sits at its base
		return image[IMG_AW'(byte_addr)];
	endfunction

	function automatic arcade_pkg::player_ctrl_t exp_ctrl(
		input arcade_pkg::player_ctrl_t keys, input logic [7:0] j0, input logic [7:0] j1);
		arcade_pkg::player_ctrl_t r;
		r      = keys;
		r.up   = r.up   | j0[3] | j1[3];
		r.down = r.down | j0[2] | j1[2];
		r.fire = r.fire | j0[4] | j1[4];
		r.bomb = r.bomb | j0[5] | j1[5];
		return r;
	endfunction

	function automatic arcade_pkg::player_ctrl_t next_key_state(
		input arcade_pkg::player_ctrl_t keys, input logic [7:0] code, input logic pressed);
		arcade_pkg::player_ctrl_t r;
		r = keys;
		case (code)
			`KEY_UP:     r.up     = pressed;
			`KEY_DOWN:   r.down   = pressed;
			`KEY_FIRE:   r.fire   = pressed;
			`KEY_BOMB:   r.bomb   = pressed;
			`KEY_COIN:   r.coin   = pressed;
			`KEY_START1: r.start1 = pressed;
			`KEY_START2: r.start2 = pressed;
			default:     r        = keys;   // unknown code
		endcase
		return r;
	endfunction

	function automatic logic [7:0] known_code(input int idx);
		case (idx)
			0: return `KEY_UP;
			1: return `KEY_DOWN;
			2: return `KEY_FIRE;
			3: return `KEY_BOMB;
			4: return `KEY_COIN;
			5: return `KEY_START1;
			default: return `KEY_START2;
		endcase
	endfunction

	// ======================================================================
	// checks and waits
	// ======================================================================
	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL %0d ns: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic probe(input int which);
		case (which)
			SIG_READY:      return ioctl_ready;
			SIG_CORE_RESET: return core_reset;
			SIG_CPU_VALID:  return cpu_rom_valid;
			default:        return snd_rom_valid;
		endcase
	endfunction

	task automatic wait_for(input int which, input logic level, input string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (probe(which) !== level && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (probe(which) !== level) begin
			n_errors++;
			$display("%s did not happen within %0d cycles at %0d ns", what, WAIT_LIMIT, $time);
		end
	endtask

	task automatic after_edge();
		@(posedge clk_sys);
		#1;
	endtask

	// compare on every valid rising edge, count fetch requests
	always @(negedge clk_sys) begin
		if (cpu_rom_valid && !cpu_valid_q)
			check_value("cpu rom byte", 32'(cpu_rom_data),
				32'(exp_rom_byte(1'b0, int'(cpu_rom_addr))));
		if (snd_rom_valid && !snd_valid_q)
			check_value("sound rom byte", 32'(snd_rom_data),
				32'(exp_rom_byte(1'b1, int'(snd_rom_addr))));
		if (arcade_io_top_i.cpu_req && !cpu_req_q)
			cpu_req_cnt++;
		if (arcade_io_top_i.snd_req && !snd_req_q)
			snd_req_cnt++;
		cpu_valid_q <= cpu_rom_valid;
		snd_valid_q <= snd_rom_valid;
		cpu_req_q   <= arcade_io_top_i.cpu_req;
		snd_req_q   <= arcade_io_top_i.snd_req;
	end

	// ======================================================================
	// stimulus tasks
	// ======================================================================
	task automatic start_download();
		after_edge();
		ioctl_download = 1'b1;
		wait_for(SIG_CORE_RESET, 1'b1, "core_reset on download start");
	endtask

	task automatic send_bytes(input int first, input int count);
		for (int i = 0; i < count; i++) begin
			wait_for(SIG_READY, 1'b1, "ioctl_ready");
			after_edge();
			ioctl_wr   = 1'b1;
			ioctl_addr = IMG_AW'(first + i);
			ioctl_dout = image[IMG_AW'(first + i)];
			after_edge();
			ioctl_wr   = 1'b0;
		end
	endtask

	task automatic end_download();
		wait_for(SIG_READY, 1'b1, "ioctl_ready after last byte");
		check_value("core_reset while downloading", 32'(core_reset), 32'(1));
		after_edge();
		ioctl_download = 1'b0;
		wait_for(SIG_CORE_RESET, 1'b0, "core_reset release after download");
	endtask

	// one read, hit tells whether valid stayed high
	task automatic read_byte(input logic snd, input int addr, output logic hit);
		after_edge();
		if (snd) begin
			snd_rom_rd   = 1'b1;
			snd_rom_addr = SND_AW'(addr);
			snd_last     = addr;
		end else begin
			cpu_rom_rd   = 1'b1;
			cpu_rom_addr = CPU_AW'(addr);
			cpu_last     = addr;
		end
		repeat (2) @(negedge clk_sys);
		hit = snd ? snd_rom_valid : cpu_rom_valid;
		if (hit)
			check_value("byte from cached word", 32'(snd ? snd_rom_data : cpu_rom_data),
				32'(exp_rom_byte(snd, addr)));
		else
			wait_for(snd ? SIG_SND_VALID : SIG_CPU_VALID, 1'b1, "fetch valid");
		after_edge();
		cpu_rom_rd = 1'b0;
		snd_rom_rd = 1'b0;
	endtask

	// both ports miss in the same cycle
	task automatic read_both(input int cpu_addr, input int snd_addr);
		after_edge();
		cpu_rom_rd   = 1'b1;
		cpu_rom_addr = CPU_AW'(cpu_addr);
		snd_rom_rd   = 1'b1;
		snd_rom_addr = SND_AW'(snd_addr);
		cpu_last     = cpu_addr;
		snd_last     = snd_addr;
		repeat (2) @(negedge clk_sys);
		check_value("cpu valid drop on joint miss", 32'(cpu_rom_valid), 32'(0));
		check_value("sound valid drop on joint miss", 32'(snd_rom_valid), 32'(0));
		wait_for(SIG_CPU_VALID, 1'b1, "cpu valid on joint read");
		wait_for(SIG_SND_VALID, 1'b1, "sound valid on joint read");
		after_edge();
		cpu_rom_rd = 1'b0;
		snd_rom_rd = 1'b0;
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		int         a;
		int         b;
		int         cnt;
		logic       hit;
		logic [7:0] code;
		logic       pressed;

		void'($urandom(32'h3423c534));
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		reset_req      = 1'b0;
		cpu_rom_rd     = 1'b0;
		cpu_rom_addr   = '0;
		snd_rom_rd     = 1'b0;
		snd_rom_addr   = '0;
		key_strobe     = 1'b0;
		key_pressed    = 1'b0;
		key_code       = '0;
		joystick_0     = '0;
		joystick_1     = '0;
		key_state      = '0;
		for (int i = 0; i < CPU_BYTES; i++)
			image[IMG_AW'(i)] = 8'($urandom);
		for (int i = 0; i < SND_BYTES; i++)
			image[IMG_AW'(SND_BYTE0 + i)] = 8'($urandom);

		repeat (3) @(posedge clk_sys);
		#1 rst_n = 1'b1;

		@(negedge clk_sys);
		check_value("core_reset after reset", 32'(core_reset), 32'(1));
		check_value("ioctl_ready after reset", 32'(ioctl_ready), 32'(1));
		check_value("cpu valid after reset", 32'(cpu_rom_valid), 32'(0));
		check_value("sound valid after reset", 32'(snd_rom_valid), 32'(0));
		check_value("ctrl after reset", {25'd0, ctrl}, 32'(0));

		// full image in one download
		start_download();
		send_bytes(0, CPU_BYTES);
		send_bytes(SND_BYTE0, SND_BYTES);
		end_download();

		for (int i = 0; i < N_READS; i++)
			read_byte(1'b0, int'($urandom % CPU_BYTES), hit);
		for (int i = 0; i < N_READS; i++)
			read_byte(1'b1, int'($urandom % SND_BYTES), hit);

		for (int i = 0; i < N_PAIRS; i++) begin
			a = int'($urandom % CPU_BYTES);
			b = int'($urandom % SND_BYTES);
			if ((a >> 1) == (cpu_last >> 1))
				a = a ^ 2;
			if ((b >> 1) == (snd_last >> 1))
				b = b ^ 2;
			read_both(a, b);
		end

		// both bytes of one word, second one from the cache
		for (int i = 0; i < N_PAIRS; i++) begin
			a = int'($urandom % CPU_BYTES) & ~1;
			if ((a >> 1) == (cpu_last >> 1))
				a = a ^ 2;
			read_byte(1'b0, a, hit);
			cnt = cpu_req_cnt;
			read_byte(1'b0, a | 1, hit);
			check_value("cpu odd byte from cache", 32'(hit), 32'(1));
			check_value("cpu requests for cached word", cpu_req_cnt, cnt);
			b = int'($urandom % SND_BYTES) & ~1;
			if ((b >> 1) == (snd_last >> 1))
				b = b ^ 2;
			read_byte(1'b1, b, hit);
			cnt = snd_req_cnt;
			read_byte(1'b1, b | 1, hit);
			check_value("sound odd byte from cache", 32'(hit), 32'(1));
			check_value("sound requests for cached word", snd_req_cnt, cnt);
		end

		// reset_req flushes the cached word
		a = int'($urandom % CPU_BYTES);
		read_byte(1'b0, a, hit);
		after_edge();
		reset_req = 1'b1;
		wait_for(SIG_CORE_RESET, 1'b1, "core_reset on reset_req");
		wait_for(SIG_CPU_VALID, 1'b0, "cpu valid drop on reset_req");
		after_edge();
		reset_req = 1'b0;
		wait_for(SIG_CORE_RESET, 1'b0, "core_reset release after reset_req");
		read_byte(1'b0, a, hit);
		check_value("cpu refetch after reset_req", 32'(hit), 32'(0));

		// rewrite the regions around two cached bytes
		b = int'($urandom % SND_BYTES);
		read_byte(1'b1, b, hit);
		for (int i = 0; i < RELOAD; i++) begin
			image[IMG_AW'((a & ~(RELOAD - 1)) + i)] ^= 8'(1 + $urandom % 255);
			image[IMG_AW'(SND_BYTE0 + (b & ~(RELOAD - 1)) + i)] ^= 8'(1 + $urandom % 255);
		end
		start_download();
		send_bytes(a & ~(RELOAD - 1), RELOAD);
		send_bytes(SND_BYTE0 + (b & ~(RELOAD - 1)), RELOAD);
		end_download();
		read_byte(1'b0, a, hit);
		check_value("cpu refetch after reload", 32'(hit), 32'(0));
		read_byte(1'b1, b, hit);
		check_value("sound refetch after reload", 32'(hit), 32'(0));

		// keys, unknown codes and joysticks
		for (int i = 0; i < N_KEYS; i++) begin
			if ($urandom % 4 == 0)
				code = 8'($urandom);
			else
				code = known_code(int'($urandom % 7));
			pressed = 1'($urandom % 2);
			after_edge();
			key_strobe  = 1'($urandom % 4 != 0);
			key_code    = code;
			key_pressed = pressed;
			if ($urandom % 3 == 0) begin
				joystick_0 = 8'($urandom);
				joystick_1 = 8'($urandom);
			end
			if (key_strobe)
				key_state = next_key_state(key_state, code, pressed);
			repeat (2) @(negedge clk_sys);
			check_value("ctrl", {25'd0, ctrl},
				{25'd0, exp_ctrl(key_state, joystick_0, joystick_1)});
		end
		after_edge();
		key_strobe = 1'b0;

		after_edge();
		$display("checks: %0d  errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+src
src/arcade_pkg.sv
src/rom_loader.sv
src/rom_fetch.sv
src/rom_port_arbiter.sv
src/rom_store.sv
src/control_mapper.sv
src/arcade_io_top.sv
bench/arcade_io_chk.sv
bench/arcade_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the arcade io testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f compile.f --top-module arcade_io_tb
out=$(./obj_dir/Varcade_io_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q '^\*\*\* PASSED \*\*\*$'
